// ==== dv/mouse_stimulus.txt ====
# P buttons dx dy | B buttons dx dy (X byte damaged) | H hold level
# E x y buttons enabled overflow, all decimal, deltas signed
E 204 153 0 1 0
P 1 10 5
P 2 -30 -8
E 184 150 2 1 0
P 4 255 -256
E 409 0 4 1 0
P 0 -256 255
P 3 -200 100
E 0 307 3 1 0
B 7 50 -50
E 0 307 3 1 0
P 5 100 -7
E 100 300 5 1 0
H 1
P 1 1 1
P 0 2 2
P 1 3 3
P 0 4 4
P 1 5 5
E 100 300 5 1 1
H 0
E 110 307 0 1 1

// ==== tb.f ====
common/ps2_pkg.sv
common/cursor_pkg.sv
ps2/ps2_host_tx.sv
ps2/ps2_packet_rx.sv
hdl/packet_fifo.sv
hdl/cursor_tracker.sv
hdl/ps2_mouse.sv
dv/ps2_mouse_model.sv
dv/tb_ps2_mouse.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ps2_mouse
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_ps2_mouse.sv ====
`timescale 1ns/1ns

module tb_ps2_mouse;

  import ps2_pkg::*;
  import cursor_pkg::*;

  localparam int INHIBIT_CYCLES = 200;
  localparam int FIFO_DEPTH     = 4;
  localparam int CLK_PERIOD     = 8;

  logic      clk;
  logic      rst;
  logic      hold;
  reg_addr_t addr;
  ps2_byte_t rdata;
  logic      enabled;
  logic      host_clk_pull;
  logic      host_data_pull;
  logic      dev_clk_pull;
  logic      dev_data_pull;
  logic      ps2_clk;
  logic      ps2_data;
  logic      mouse_send;
  logic      mouse_bad;
  buttons_t  mouse_buttons;
  delta_t    mouse_dx;
  delta_t    mouse_dy;
  logic      mouse_busy;
  ps2_byte_t cmd_byte;
  logic      cmd_parity;
  logic      cmd_stop;
  int        watchdog_ns;

  // one entry per stimulus command, arguments in file order.
  byte ops[$];
  int  arg_a[$];
  int  arg_b[$];
  int  arg_c[$];
  int  arg_d[$];
  int  arg_e[$];

  // both sides only ever pull low, so each line is the AND of the releases.
  assign ps2_clk  = !(host_clk_pull || dev_clk_pull);
  assign ps2_data = !(host_data_pull || dev_data_pull);

  ps2_mouse #(
    .INHIBIT_CYCLES(INHIBIT_CYCLES),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .X_MAX         (409),
    .Y_MAX         (307)
  ) i_ps2_mouse (
    .clk          (clk),
    .rst          (rst),
    .ps2_clk_in   (ps2_clk),
    .ps2_data_in  (ps2_data),
    .hold         (hold),
    .addr         (addr),
    .ps2_clk_pull (host_clk_pull),
    .ps2_data_pull(host_data_pull),
    .enabled      (enabled),
    .rdata        (rdata)
  );

  ps2_mouse_model #(
    .HALF_PERIOD(12)
  ) i_mouse_model (
    .clk       (clk),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .send      (mouse_send),
    .send_bad  (mouse_bad),
    .buttons   (mouse_buttons),
    .dx        (mouse_dx),
    .dy        (mouse_dy),
    .clk_pull  (dev_clk_pull),
    .data_pull (dev_data_pull),
    .busy      (mouse_busy),
    .cmd_byte  (cmd_byte),
    .cmd_parity(cmd_parity),
    .cmd_stop  (cmd_stop)
  );

  always #4 clk = ~clk;

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_pos(input string name, input pos_t got, input pos_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input ps2_byte_t got, input ps2_byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic load_stimulus();
    int fd;
    int ch;
    int n;
    int a;
    int b;
    int c;
    int d;
    int e;
    fd = $fopen("dv/mouse_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file dv/mouse_stimulus.txt");
      stop_run();
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      a = 0;
      b = 0;
      c = 0;
      d = 0;
      e = 0;
      if (ch == "#") begin
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else if (ch == "P" || ch == "B") begin
        n = $fscanf(fd, " %d %d %d", a, b, c);
        if (n != 3) begin
          $display("packet line in the stimulus file lacks its three fields");
          stop_run();
        end
      end else if (ch == "H") begin
        n = $fscanf(fd, " %d", a);
        if (n != 1) begin
          $display("hold line in the stimulus file lacks its level");
          stop_run();
        end
      end else if (ch == "E") begin
        n = $fscanf(fd, " %d %d %d %d %d", a, b, c, d, e);
        if (n != 5) begin
          $display("expect line in the stimulus file lacks its five fields");
          stop_run();
        end
      end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
        $display("unknown command character %0d in the stimulus file", ch);
        stop_run();
      end
      if (ch == "P" || ch == "B" || ch == "H" || ch == "E") begin
        ops.push_back(byte'(ch));
        arg_a.push_back(a);
        arg_b.push_back(b);
        arg_c.push_back(c);
        arg_d.push_back(d);
        arg_e.push_back(e);
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic wait_model_idle();
    @(posedge clk);
    while (mouse_busy) @(posedge clk);
  endtask

  task automatic drive_packet(input buttons_t b, input delta_t x, input delta_t y,
                              input logic bad);
    @(posedge clk);
    mouse_send    <= 1'b1;
    mouse_bad     <= bad;
    mouse_buttons <= b;
    mouse_dx      <= x;
    mouse_dy      <= y;
    @(posedge clk);
    mouse_send <= 1'b0;
    wait_model_idle();
  endtask

  task automatic read_reg(input reg_addr_t a, output ps2_byte_t data);
    @(posedge clk);
    addr <= a;
    @(posedge clk);
    data = rdata;
  endtask

  task automatic check_registers(input int ex, input int ey, input int eb, input int een,
                                 input int eov);
    ps2_byte_t status;
    ps2_byte_t x_lo;
    ps2_byte_t y_lo;
    ps2_byte_t hi;
    pos_t      x_exp;
    pos_t      y_exp;
    x_exp = pos_t'(ex);
    y_exp = pos_t'(ey);
    wait_model_idle();
    repeat (20) @(posedge clk);
    read_reg(REG_STATUS, status);
    read_reg(REG_X_LO, x_lo);
    read_reg(REG_Y_LO, y_lo);
    read_reg(REG_HI, hi);
    check_pos("x position", {hi[0], x_lo}, x_exp);
    check_pos("y position", {hi[1], y_lo}, y_exp);
    check_status("REG_HI", hi, {6'b000000, y_exp[8], x_exp[8]});
    check_status("REG_STATUS", status, {eov[0], een[0], 3'b000, eb[2:0]});
    check_flag("enabled", enabled, een[0]);
  endtask

  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    stop_run();
  end

  initial begin
    int i;
    clk           = 1'b0;
    watchdog_ns   = 0;
    rst           <= 1'b1;
    hold          <= 1'b0;
    addr          <= REG_STATUS;
    mouse_send    <= 1'b0;
    mouse_bad     <= 1'b0;
    mouse_buttons <= '0;
    mouse_dx      <= '0;
    mouse_dy      <= '0;
    load_stimulus();
    watchdog_ns = (ops.size() * 3 * 11 * 24 + INHIBIT_CYCLES + 2000) * CLK_PERIOD;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // the model stays busy until it has taken the command and sent its acknowledge.
    wait_model_idle();
    check_status("host command", cmd_byte, 8'hF4);
    if ((^{cmd_byte, cmd_parity}) !== 1'b1) begin
      $display("host command parity bit does not give odd parity");
      stop_run();
    end
    if (cmd_stop !== 1'b1) begin
      $display("host command stop bit was not high");
      stop_run();
    end
    for (i = 0; i < ops.size(); i++) begin
      case (ops[i])
        "P": drive_packet(buttons_t'(arg_a[i]), delta_t'(arg_b[i]), delta_t'(arg_c[i]), 1'b0);
        "B": drive_packet(buttons_t'(arg_a[i]), delta_t'(arg_b[i]), delta_t'(arg_c[i]), 1'b1);
        "H": begin
          @(posedge clk);
          hold <= arg_a[i][0];
        end
        default: check_registers(arg_a[i], arg_b[i], arg_c[i], arg_d[i], arg_e[i]);
      endcase
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== dv/ps2_mouse_model.sv ====
`timescale 1ns/1ns

module ps2_mouse_model #(
  parameter int HALF_PERIOD = 12
) (
  input  logic                 clk,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  input  logic                 send,
  input  logic                 send_bad,
  input  cursor_pkg::buttons_t buttons,
  input  cursor_pkg::delta_t   dx,
  input  cursor_pkg::delta_t   dy,
  output logic                 clk_pull,
  output logic                 data_pull,
  output logic                 busy,
  output ps2_pkg::ps2_byte_t   cmd_byte,
  output logic                 cmd_parity,
  output logic                 cmd_stop
);

  import ps2_pkg::*;
  import cursor_pkg::*;

  task automatic half_period();
    repeat (HALF_PERIOD) @(posedge clk);
  endtask

  // the host has already put its start bit on the line when this is called.
  task automatic receive_command();
    logic [9:0] bits;
    int         i;
    bits = '0;
    half_period();
    for (i = 0; i < 10; i++) begin
      clk_pull <= 1'b1;
      half_period();
      // host data changes shortly after the fall, so the end of the low phase is safe.
      bits[i] = ps2_data;
      clk_pull <= 1'b0;
      half_period();
    end
    // Line acknowledge, data held low across one more clock pulse.
    data_pull <= 1'b1;
    half_period();
    clk_pull <= 1'b1;
    half_period();
    clk_pull  <= 1'b0;
    data_pull <= 1'b0;
    half_period();
    cmd_byte   <= bits[7:0];
    cmd_parity <= bits[8];
    cmd_stop   <= bits[9];
  endtask

  task automatic send_byte(input ps2_byte_t b, input logic good_parity);
    logic [10:0] frame;
    logic        parity;
    int          i;
    parity = good_parity ? ~^b : ^b;
    frame  = {1'b1, parity, b, 1'b0};
    for (i = 0; i < 11; i++) begin
      data_pull <= ~frame[i];
      half_period();
      clk_pull <= 1'b1;
      half_period();
      clk_pull <= 1'b0;
    end
    data_pull <= 1'b0;
    half_period();
  endtask

  task automatic send_packet(input buttons_t b, input delta_t x, input delta_t y,
                             input logic bad);
    ps2_byte_t status;
    status = {2'b00, y[8], x[8], 1'b1, b};
    send_byte(status, 1'b1);
    send_byte(x[7:0], !bad);
    // a damaged packet is cut short after its X byte.
    if (!bad) begin
      send_byte(y[7:0], 1'b1);
    end
  endtask

  initial begin
    clk_pull   <= 1'b0;
    data_pull  <= 1'b0;
    busy       <= 1'b1;
    cmd_byte   <= '0;
    cmd_parity <= 1'b0;
    cmd_stop   <= 1'b0;
    @(posedge clk);
    while (ps2_clk !== 1'b0) @(posedge clk);
    while (!(ps2_clk === 1'b1 && ps2_data === 1'b0)) @(posedge clk);
    receive_command();
    // acknowledge of the enable command.
    send_byte(8'hFA, 1'b1);
    busy <= 1'b0;
    forever begin
      @(posedge clk);
      if (send) begin
        busy <= 1'b1;
        send_packet(buttons, dx, dy, send_bad);
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/ps2_mouse.sv ====
`timescale 1ns/1ns

module ps2_mouse #(
  parameter int INHIBIT_CYCLES = 10000,
  parameter int FIFO_DEPTH     = 4,
  parameter int X_MAX          = 409,
  parameter int Y_MAX          = 307
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ps2_clk_in,
  input  logic                  ps2_data_in,
  input  logic                  hold,
  input  cursor_pkg::reg_addr_t addr,
  output logic                  ps2_clk_pull,
  output logic                  ps2_data_pull,
  output logic                  enabled,
  output ps2_pkg::ps2_byte_t    rdata
);

  import ps2_pkg::*;

  logic          tx_done;
  logic          ack_seen;
  logic          pkt_valid;
  mouse_packet_t pkt_data;
  mouse_packet_t fifo_rdata;
  logic          fifo_empty;
  logic          pop;
  logic          overflow;

  ps2_host_tx #(
    .INHIBIT_CYCLES(INHIBIT_CYCLES)
  ) i_host_tx (
    .clk          (clk),
    .rst          (rst),
    .ps2_clk_in   (ps2_clk_in),
    .ack_seen     (ack_seen),
    .ps2_clk_pull (ps2_clk_pull),
    .ps2_data_pull(ps2_data_pull),
    .tx_done      (tx_done),
    .enabled      (enabled)
  );

  ps2_packet_rx i_packet_rx (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk_in (ps2_clk_in),
    .ps2_data_in(ps2_data_in),
    .tx_done    (tx_done),
    .enabled    (enabled),
    .ack_seen   (ack_seen),
    .pkt_valid  (pkt_valid),
    .pkt_data   (pkt_data)
  );

  packet_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_packet_fifo (
    .clk     (clk),
    .rst     (rst),
    .push    (pkt_valid),
    .wdata   (pkt_data),
    .pop     (pop),
    .rdata   (fifo_rdata),
    .empty   (fifo_empty),
    .overflow(overflow)
  );

  cursor_tracker #(
    .X_MAX(X_MAX),
    .Y_MAX(Y_MAX)
  ) i_cursor_tracker (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .fifo_empty(fifo_empty),
    .pkt_data  (fifo_rdata),
    .enabled   (enabled),
    .overflow  (overflow),
    .addr      (addr),
    .pop       (pop),
    .rdata     (rdata)
  );

endmodule

// ==== hdl/cursor_tracker.sv ====
`timescale 1ns/1ns

module cursor_tracker #(
  parameter int X_MAX = 409,
  parameter int Y_MAX = 307
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   hold,
  input  logic                   fifo_empty,
  input  ps2_pkg::mouse_packet_t pkt_data,
  input  logic                   enabled,
  input  logic                   overflow,
  input  cursor_pkg::reg_addr_t  addr,
  output logic                   pop,
  output ps2_pkg::ps2_byte_t     rdata
);

  import ps2_pkg::*;
  import cursor_pkg::*;

  pos_t     x;
  pos_t     y;
  buttons_t buttons;
  delta_t   dx;
  delta_t   dy;

  // the sum is kept at 10 bits, so a negative result shows as a set top bit.
  function automatic pos_t step(input pos_t p, input delta_t d, input pos_t lim);
    logic [9:0] sum;
    sum = {1'b0, p} + {d[8], d};
    if (d[8] && sum[9]) begin
      step = '0;
    end else if (sum > {1'b0, lim}) begin
      step = lim;
    end else begin
      step = sum[8:0];
    end
  endfunction

  assign dx = {pkt_data[2], pkt_data[18:11]};
  assign dy = {pkt_data[1], pkt_data[10:3]};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pop     <= 1'b0;
      x       <= pos_t'(X_MAX / 2);
      y       <= pos_t'(Y_MAX / 2);
      buttons <= '0;
    end else begin
      // Skip a cycle after each pop so that empty has caught up.
      pop <= !fifo_empty && !hold && !pop;
      if (pop) begin
        x       <= step(x, dx, pos_t'(X_MAX));
        y       <= step(y, dy, pos_t'(Y_MAX));
        buttons <= pkt_data[21:19];
      end
    end
  end

  always_comb begin
    unique case (addr)
      REG_STATUS: rdata = {overflow, enabled, 3'b000, buttons};
      REG_X_LO:   rdata = x[7:0];
      REG_Y_LO:   rdata = y[7:0];
      REG_HI:     rdata = {6'b000000, y[8], x[8]};
    endcase
  end

  a_pos_in_box: assert property (@(posedge clk) disable iff (rst)
    (x <= pos_t'(X_MAX)) && (y <= pos_t'(Y_MAX)))
    else $error("cursor left the screen box");

endmodule

// ==== hdl/packet_fifo.sv ====
`timescale 1ns/1ns

module packet_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  ps2_pkg::mouse_packet_t wdata,
  input  logic                   pop,
  output ps2_pkg::mouse_packet_t rdata,
  output logic                   empty,
  output logic                   overflow
);

  import ps2_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mouse_packet_t    mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;
  assign rdata   = mem[rd_ptr];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push != do_pop) begin
        count <= do_push ? count + 1'b1 : count - 1'b1;
      end
      // a packet that finds no room is lost for good.
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty)
    else $error("consumer popped an empty packet FIFO");

endmodule

// ==== ps2/ps2_packet_rx.sv ====
`timescale 1ns/1ns

module ps2_packet_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ps2_clk_in,
  input  logic                    ps2_data_in,
  input  logic                    tx_done,
  input  logic                    enabled,
  output logic                    ack_seen,
  output logic                    pkt_valid,
  output ps2_pkg::mouse_packet_t  pkt_data
);

  import ps2_pkg::*;

  logic                  clk_meta;
  logic                  clk_sync;
  logic                  clk_prev;
  logic                  data_meta;
  logic                  data_sync;
  logic [3:0]            bit_cnt;
  logic [1:0]            byte_idx;
  logic [FRAME_BITS-1:0] frame;
  logic [FRAME_BITS-1:0] frame_next;
  logic                  sample;
  logic                  frame_end;
  logic                  frame_ok;
  ps2_byte_t             rx_byte;
  ps2_byte_t             status_b;
  ps2_byte_t             x_b;

  // data is stable on the falling device clock, shifted in LSB first.
  assign sample     = clk_prev & ~clk_sync & tx_done;
  assign frame_next = {data_sync, frame[FRAME_BITS-1:1]};
  assign frame_end  = sample && (bit_cnt == 4'(FRAME_BITS - 1));
  assign rx_byte    = frame_next[8:1];
  assign frame_ok   = !frame_next[0] && frame_next[FRAME_BITS-1] && (^frame_next[9:1]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      ack_seen  <= 1'b0;
      pkt_valid <= 1'b0;
    end else begin
      clk_meta  <= ps2_clk_in;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= ps2_data_in;
      data_sync <= data_meta;
      ack_seen  <= 1'b0;
      pkt_valid <= 1'b0;
      if (sample) begin
        bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
      end
      if (frame_end) begin
        if (!frame_ok) begin
          // A damaged byte throws away whatever part of the packet came before it.
          byte_idx <= '0;
        end else if (!enabled) begin
          ack_seen <= (rx_byte == RSP_ACK);
        end else if (byte_idx == 2'd2) begin
          byte_idx  <= '0;
          pkt_valid <= 1'b1;
        end else begin
          byte_idx <= byte_idx + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      frame <= frame_next;
    end
    if (frame_end && frame_ok && enabled) begin
      case (byte_idx)
        2'd0:    status_b <= rx_byte;
        2'd1:    x_b <= rx_byte;
        default: pkt_data <= {status_b, x_b, rx_byte, status_b[4], status_b[5], status_b[3]};
      endcase
    end
  end

  a_no_early_packet: assert property (@(posedge clk) disable iff (rst)
    pkt_valid |-> enabled)
    else $error("packet strobed before the mouse acknowledged enable");

endmodule

// ==== ps2/ps2_host_tx.sv ====
`timescale 1ns/1ns

module ps2_host_tx #(
  parameter int INHIBIT_CYCLES = 10000
) (
  input  logic clk,
  input  logic rst,
  input  logic ps2_clk_in,
  input  logic ack_seen,
  output logic ps2_clk_pull,
  output logic ps2_data_pull,
  output logic tx_done,
  output logic enabled
);

  import ps2_pkg::*;

  typedef enum logic [2:0] {INHIBIT, START, DATA, STOP, WAIT_ACK, DONE} tx_state_t;

  tx_state_t   state;
  logic [13:0] inhibit_cnt;
  logic [3:0]  bit_cnt;
  logic [8:0]  shift;
  logic        clk_meta;
  logic        clk_sync;
  logic        clk_prev;
  logic        clk_fall;

  // the device drives the clock once the host has released it.
  assign clk_fall = clk_prev & ~clk_sync;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= INHIBIT;
      inhibit_cnt   <= '0;
      bit_cnt       <= '0;
      shift         <= '0;
      clk_meta      <= 1'b1;
      clk_sync      <= 1'b1;
      clk_prev      <= 1'b1;
      ps2_clk_pull  <= 1'b0;
      ps2_data_pull <= 1'b0;
      tx_done       <= 1'b0;
      enabled       <= 1'b0;
    end else begin
      clk_meta <= ps2_clk_in;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
      case (state)
        INHIBIT: begin
          ps2_clk_pull <= 1'b1;
          if (inhibit_cnt == 14'(INHIBIT_CYCLES - 1)) begin
            ps2_data_pull <= 1'b1;
            shift         <= {~^CMD_ENABLE, CMD_ENABLE};
            state         <= START;
          end else begin
            inhibit_cnt <= inhibit_cnt + 14'd1;
          end
        end
        START: begin
          // Data is already low, so letting go of the clock is the request to send.
          ps2_clk_pull <= 1'b0;
          bit_cnt      <= '0;
          state        <= DATA;
        end
        DATA: begin
          if (clk_fall) begin
            ps2_data_pull <= ~shift[0];
            shift         <= {1'b0, shift[8:1]};
            if (bit_cnt == 4'd8) begin
              state <= STOP;
            end else begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
        end
        STOP: begin
          if (clk_fall) begin
            ps2_data_pull <= 1'b0;
            state         <= WAIT_ACK;
          end
        end
        WAIT_ACK: begin
          // the next falling edge is the line acknowledge, after it the mouse answers.
          if (clk_fall) begin
            tx_done <= 1'b1;
          end
          if (ack_seen) begin
            enabled <= 1'b1;
            state   <= DONE;
          end
        end
        default: begin
        end
      endcase
    end
  end

  a_no_double_pull: assert property (@(posedge clk) disable iff (rst)
    (state inside {DATA, STOP, WAIT_ACK, DONE}) |-> !(ps2_clk_pull && ps2_data_pull))
    else $error("host pulls clock and data low together after the start phase");

endmodule

// ==== common/cursor_pkg.sv ====
package cursor_pkg;

  // Screen coordinate, never negative after clamping.
  typedef logic [8:0] pos_t;

  // Movement as sent by the mouse, sign bit taken from the status byte.
  typedef logic signed [8:0] delta_t;

  // Left, right and middle button, in status byte order.
  typedef logic [2:0] buttons_t;

  typedef enum logic [1:0] {
    REG_STATUS = 2'd0,
    REG_X_LO   = 2'd1,
    REG_Y_LO   = 2'd2,
    REG_HI     = 2'd3
  } reg_addr_t;

endpackage

// ==== common/ps2_pkg.sv ====
package ps2_pkg;

  // One data byte as it travels inside a device or host frame.
  typedef logic [7:0] ps2_byte_t;

  // Movement packet fields in arrival order.
  // The status byte sits at [26:19], the X byte at [18:11] and the Y byte at [10:3].
  // The low bits repeat the X sign, the Y sign and the sync bit of the status byte.
  typedef logic [26:0] mouse_packet_t;

  // Enable data reporting, the only command the host ever sends.
  localparam ps2_byte_t CMD_ENABLE = 8'hF4;

  // Acknowledge returned by the mouse after a command.
  localparam ps2_byte_t RSP_ACK = 8'hFA;

  // Start bit, eight data bits, parity and stop.
  localparam int FRAME_BITS = 11;

endpackage
